//--- design/cache_dma_pkg.sv
// cache-side DMA types and block geometry, imported by the adapters, endpoint and top
`default_nettype none

package cache_dma_pkg;

  // byte address and data word sizes
  localparam int DMA_ADDR_WIDTH = 16;
  localparam int DMA_DATA_WIDTH = 32;

  // one block is a burst of words
  localparam int BURST_LEN = 4;
  localparam int BURST_LOG2 = $clog2(BURST_LEN);
  localparam int WORD_OFFSET = $clog2(DMA_DATA_WIDTH / 8);

  // endpoint memory, indexed by word
  localparam int MEM_WORDS = 256;
  localparam int MEM_ADDR_WIDTH = $clog2(MEM_WORDS);
  localparam int BLOCK_IDX_WIDTH = MEM_ADDR_WIDTH - BURST_LOG2;

  // mask has one bit per word of the block
  typedef struct packed {
    logic                      write_not_read;
    logic [DMA_ADDR_WIDTH-1:0] addr;
    logic [BURST_LEN-1:0]      mask;
  } dma_pkt_s;

  typedef struct packed {
    logic                      v;
    logic [DMA_DATA_WIDTH-1:0] data;
  } dma_data_s;

endpackage

`default_nettype wire

//--- design/wh_flit_pkg.sv
// wormhole link definitions shared by the adapters, the arbiter and the memory endpoint
`default_nettype none

package wh_flit_pkg;

  // a flit carries exactly one DMA data word
  localparam int FLIT_WIDTH = cache_dma_pkg::DMA_DATA_WIDTH;
  localparam int CID_WIDTH = 1;
  localparam int LEN_WIDTH = 4;
  localparam int OPCODE_WIDTH = 2;

  typedef enum logic [OPCODE_WIDTH-1:0] {
    e_wh_read,
    e_wh_write_non_masked,
    e_wh_write_masked,
    e_wh_read_resp
  } wh_opcode_e;

  // len counts the flits that follow the header
  typedef struct packed {
    wh_opcode_e                                           opcode;
    logic [LEN_WIDTH-1:0]                                 len;
    logic [CID_WIDTH-1:0]                                 src_cid;
    logic [FLIT_WIDTH-OPCODE_WIDTH-LEN_WIDTH-CID_WIDTH-1:0] unused;
  } wh_header_s;

  typedef union packed {
    wh_header_s            hdr;
    logic [FLIT_WIDTH-1:0] raw;
  } wh_flit_u;

  // forward half of a link, ready runs the other way
  typedef struct packed {
    logic     v;
    wh_flit_u flit;
  } wh_link_s;

endpackage

`default_nettype wire

//--- design/dma_to_wormhole.sv
// per-cache adapter: DMA packets out as wormhole request flits, return flits back as fill data
`default_nettype none

module dma_to_wormhole
  import cache_dma_pkg::*;
  import wh_flit_pkg::*;
#(
  parameter logic [CID_WIDTH-1:0] src_cid_p = '0
) (
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  input  wire dma_pkt_s  dma_pkt_i,
  input  wire logic      dma_pkt_v_i,
  output logic           dma_pkt_ready_o,
  input  wire dma_data_s dma_wdata_i,
  output logic           dma_wdata_ready_o,
  output dma_data_s      dma_rdata_o,
  input  wire logic      dma_rdata_ready_i,
  output wh_link_s       req_link_o,
  input  wire logic      req_ready_i,
  input  wire wh_link_s  ret_link_i,
  output logic           ret_ready_o
);

  typedef enum logic [2:0] {
    e_send_reset,
    e_send_header,
    e_send_addr,
    e_send_mask,
    e_send_data
  } send_state_e;

  typedef enum logic [1:0] {
    e_recv_reset,
    e_recv_ready,
    e_recv_data
  } recv_state_e;

  send_state_e send_state_r, send_state_n;
  recv_state_e recv_state_r, recv_state_n;

  // two-entry packet queue, keeps writeback->fill free of bubbles
  dma_pkt_s   pkt_q_mem [2];
  logic       pkt_q_wptr_r, pkt_q_rptr_r;
  logic [1:0] pkt_q_cnt_r;
  logic       pkt_q_enq, pkt_q_deq, pkt_q_v;
  dma_pkt_s   pkt_q_head;

  assign dma_pkt_ready_o = (pkt_q_cnt_r != 2'd2);
  assign pkt_q_enq = dma_pkt_v_i & dma_pkt_ready_o;
  assign pkt_q_v = (pkt_q_cnt_r != 2'd0);
  assign pkt_q_head = pkt_q_mem[pkt_q_rptr_r];

  // return flit queue
  wh_flit_u   ret_q_mem [2];
  logic       ret_q_wptr_r, ret_q_rptr_r;
  logic [1:0] ret_q_cnt_r;
  logic       ret_q_enq, ret_q_deq, ret_q_v;

  assign ret_ready_o = (ret_q_cnt_r != 2'd2);
  assign ret_q_enq = ret_link_i.v & ret_ready_o;
  assign ret_q_v = (ret_q_cnt_r != 2'd0);

  always_ff @(posedge clk_i) begin
    if (pkt_q_enq) begin
      pkt_q_mem[pkt_q_wptr_r] <= dma_pkt_i;
    end
    if (ret_q_enq) begin
      ret_q_mem[ret_q_wptr_r] <= ret_link_i.flit;
    end
  end

  // burst counters for the outgoing and returning data
  logic [BURST_LOG2-1:0] send_beat_r, recv_beat_r;
  logic                  send_beat_last, recv_beat_last;
  logic                  send_beat_up, recv_beat_up;

  assign send_beat_last = (send_beat_r == BURST_LOG2'(BURST_LEN - 1));
  assign recv_beat_last = (recv_beat_r == BURST_LOG2'(BURST_LEN - 1));

  // header depends on the packet at the queue head
  wh_header_s hdr_flit;
  logic       mask_all_one;

  assign mask_all_one = &pkt_q_head.mask;

  always_comb begin
    hdr_flit = '0;
    hdr_flit.src_cid = src_cid_p;
    if (!pkt_q_head.write_not_read) begin
      hdr_flit.opcode = e_wh_read;
      hdr_flit.len = LEN_WIDTH'(1);
    end else if (mask_all_one) begin
      hdr_flit.opcode = e_wh_write_non_masked;
      hdr_flit.len = LEN_WIDTH'(1 + BURST_LEN);
    end else begin
      hdr_flit.opcode = e_wh_write_masked;
      hdr_flit.len = LEN_WIDTH'(2 + BURST_LEN);
    end
  end

  always_comb begin
    send_state_n = send_state_r;
    pkt_q_deq = 1'b0;
    send_beat_up = 1'b0;
    dma_wdata_ready_o = 1'b0;
    req_link_o.v = 1'b0;
    req_link_o.flit.raw = dma_wdata_i.data;
    case (send_state_r)
      e_send_reset: send_state_n = e_send_header;
      e_send_header: begin
        req_link_o.flit.hdr = hdr_flit;
        req_link_o.v = pkt_q_v;
        if (pkt_q_v && req_ready_i) send_state_n = e_send_addr;
      end
      e_send_addr: begin
        req_link_o.flit.raw = FLIT_WIDTH'(pkt_q_head.addr);
        req_link_o.v = pkt_q_v;
        if (pkt_q_v && req_ready_i) begin
          // a masked write stays queued until its mask flit goes out
          if (!pkt_q_head.write_not_read) begin
            pkt_q_deq = 1'b1;
            send_state_n = e_send_header;
          end else if (mask_all_one) begin
            pkt_q_deq = 1'b1;
            send_state_n = e_send_data;
          end else begin
            send_state_n = e_send_mask;
          end
        end
      end
      e_send_mask: begin
        req_link_o.flit.raw = FLIT_WIDTH'(pkt_q_head.mask);
        req_link_o.v = pkt_q_v;
        if (pkt_q_v && req_ready_i) begin
          pkt_q_deq = 1'b1;
          send_state_n = e_send_data;
        end
      end
      e_send_data: begin
        req_link_o.v = dma_wdata_i.v;
        dma_wdata_ready_o = req_ready_i;
        if (dma_wdata_i.v && req_ready_i) begin
          send_beat_up = 1'b1;
          if (send_beat_last) send_state_n = e_send_header;
        end
      end
      default: send_state_n = e_send_header;
    endcase
  end

  always_comb begin
    recv_state_n = recv_state_r;
    ret_q_deq = 1'b0;
    recv_beat_up = 1'b0;
    dma_rdata_o.v = 1'b0;
    dma_rdata_o.data = ret_q_mem[ret_q_rptr_r].raw;
    case (recv_state_r)
      e_recv_reset: recv_state_n = e_recv_ready;
      e_recv_ready: begin
        // drop the response header
        ret_q_deq = ret_q_v;
        if (ret_q_v) recv_state_n = e_recv_data;
      end
      e_recv_data: begin
        dma_rdata_o.v = ret_q_v;
        ret_q_deq = ret_q_v & dma_rdata_ready_i;
        recv_beat_up = ret_q_deq;
        if (ret_q_deq && recv_beat_last) recv_state_n = e_recv_ready;
      end
      default: recv_state_n = e_recv_ready;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_state_r <= e_send_reset;
      recv_state_r <= e_recv_reset;
      pkt_q_wptr_r <= 1'b0;
      pkt_q_rptr_r <= 1'b0;
      pkt_q_cnt_r <= 2'd0;
      ret_q_wptr_r <= 1'b0;
      ret_q_rptr_r <= 1'b0;
      ret_q_cnt_r <= 2'd0;
      send_beat_r <= '0;
      recv_beat_r <= '0;
    end else begin
      send_state_r <= send_state_n;
      recv_state_r <= recv_state_n;
      pkt_q_wptr_r <= pkt_q_wptr_r ^ pkt_q_enq;
      pkt_q_rptr_r <= pkt_q_rptr_r ^ pkt_q_deq;
      pkt_q_cnt_r <= pkt_q_cnt_r + 2'(pkt_q_enq) - 2'(pkt_q_deq);
      ret_q_wptr_r <= ret_q_wptr_r ^ ret_q_enq;
      ret_q_rptr_r <= ret_q_rptr_r ^ ret_q_deq;
      ret_q_cnt_r <= ret_q_cnt_r + 2'(ret_q_enq) - 2'(ret_q_deq);
      if (send_beat_up) send_beat_r <= send_beat_last ? '0 : send_beat_r + 1'b1;
      if (recv_beat_up) recv_beat_r <= recv_beat_last ? '0 : recv_beat_r + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/wh_packet_arbiter.sv
// round-robin arbiter that locks the shared request link to one packet at a time
`default_nettype none

module wh_packet_arbiter
  import wh_flit_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  input  wire wh_link_s req_link_i [2],
  output logic [1:0]    req_ready_o,
  output wh_link_s      mem_link_o,
  input  wire logic     mem_ready_i
);

  logic                 prio_r;
  logic                 held_r;
  logic                 grant_r;
  logic [LEN_WIDTH-1:0] count_r;
  logic                 sel;
  logic                 xfer;

  // while idle the preferred requester wins if it has a flit
  always_comb begin
    if (held_r) begin
      sel = grant_r;
    end else if (req_link_i[prio_r].v) begin
      sel = prio_r;
    end else begin
      sel = ~prio_r;
    end
    mem_link_o = req_link_i[sel];
    req_ready_o = '0;
    req_ready_o[sel] = mem_ready_i;
  end

  assign xfer = mem_link_o.v & mem_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_r <= 1'b0;
      held_r <= 1'b0;
      grant_r <= 1'b0;
      count_r <= '0;
    end else if (xfer) begin
      if (!held_r) begin
        // header flit, lock on for len more flits
        held_r <= 1'b1;
        grant_r <= sel;
        prio_r <= ~sel;
        count_r <= mem_link_o.flit.hdr.len;
      end else begin
        count_r <= count_r - 1'b1;
        if (count_r == LEN_WIDTH'(1)) held_r <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/wh_memory_endpoint.sv
// memory endpoint: applies write packets to a word memory and answers reads per source cache
`default_nettype none

module wh_memory_endpoint
  import cache_dma_pkg::*;
  import wh_flit_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  input  wire wh_link_s mem_link_i,
  output logic          mem_ready_o,
  output wh_link_s      ret_link_o [2],
  input  wire logic [1:0] ret_ready_i
);

  typedef enum logic [2:0] {
    e_ep_idle,
    e_ep_addr,
    e_ep_mask,
    e_ep_data,
    e_ep_resp_hdr,
    e_ep_resp_data
  } ep_state_e;

  ep_state_e state_r, state_n;

  logic [DMA_DATA_WIDTH-1:0]  mem_r [MEM_WORDS];

  // packet fields captured from header, address and mask flits
  wh_opcode_e                 op_r;
  logic [CID_WIDTH-1:0]       cid_r;
  logic [BLOCK_IDX_WIDTH-1:0] blk_r;
  logic [BURST_LEN-1:0]       mask_r;

  logic [BURST_LOG2-1:0]      beat_r;
  logic                       beat_last;
  logic                       beat_step;
  logic [MEM_ADDR_WIDTH-1:0]  mem_addr;
  wh_flit_u                   in_flit;
  logic                       in_xfer;
  logic                       resp_v;
  wh_flit_u                   resp_flit;

  assign in_flit = mem_link_i.flit;
  assign mem_ready_o = (state_r != e_ep_resp_hdr) && (state_r != e_ep_resp_data);
  assign in_xfer = mem_link_i.v & mem_ready_o;
  assign beat_last = (beat_r == BURST_LOG2'(BURST_LEN - 1));
  assign mem_addr = {blk_r, beat_r};

  always_comb begin
    state_n = state_r;
    beat_step = 1'b0;
    resp_v = 1'b0;
    resp_flit.raw = mem_r[mem_addr];
    case (state_r)
      e_ep_idle: if (in_xfer) state_n = e_ep_addr;
      e_ep_addr: begin
        if (in_xfer) begin
          case (op_r)
            e_wh_read:         state_n = e_ep_resp_hdr;
            e_wh_write_masked: state_n = e_ep_mask;
            default:           state_n = e_ep_data;
          endcase
        end
      end
      e_ep_mask: if (in_xfer) state_n = e_ep_data;
      e_ep_data: begin
        beat_step = in_xfer;
        if (in_xfer && beat_last) state_n = e_ep_idle;
      end
      e_ep_resp_hdr: begin
        resp_v = 1'b1;
        resp_flit.hdr = '0;
        resp_flit.hdr.opcode = e_wh_read_resp;
        resp_flit.hdr.len = LEN_WIDTH'(BURST_LEN);
        resp_flit.hdr.src_cid = cid_r;
        if (ret_ready_i[cid_r]) state_n = e_ep_resp_data;
      end
      e_ep_resp_data: begin
        // data word is read in the cycle it is offered
        resp_v = 1'b1;
        beat_step = ret_ready_i[cid_r];
        if (ret_ready_i[cid_r] && beat_last) state_n = e_ep_idle;
      end
      default: state_n = e_ep_idle;
    endcase
  end

  // response goes only to the cache that sent the read
  always_comb begin
    for (int c = 0; c < 2; c++) begin
      ret_link_o[c].v = resp_v & (cid_r == CID_WIDTH'(c));
      ret_link_o[c].flit = resp_flit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_ep_idle;
      beat_r <= '0;
    end else begin
      state_r <= state_n;
      if (beat_step) beat_r <= beat_last ? '0 : beat_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == e_ep_idle && in_xfer) begin
      op_r <= in_flit.hdr.opcode;
      cid_r <= in_flit.hdr.src_cid;
      mask_r <= '1;
    end
    if (state_r == e_ep_addr && in_xfer) begin
      blk_r <= in_flit.raw[WORD_OFFSET + BURST_LOG2 +: BLOCK_IDX_WIDTH];
    end
    if (state_r == e_ep_mask && in_xfer) begin
      mask_r <= in_flit.raw[BURST_LEN-1:0];
    end
    if (state_r == e_ep_data && in_xfer && mask_r[beat_r]) begin
      mem_r[mem_addr] <= in_flit.raw;
    end
  end

endmodule

`default_nettype wire

//--- design/cache_dma_top.sv
// top level: two cache adapters sharing one request link into the memory endpoint
`default_nettype none

module cache_dma_top
  import cache_dma_pkg::*;
  import wh_flit_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       reset_i,
  input  wire dma_pkt_s   dma_pkt_i [2],
  input  wire logic [1:0] dma_pkt_v_i,
  output logic [1:0]      dma_pkt_ready_o,
  input  wire dma_data_s  dma_wdata_i [2],
  output logic [1:0]      dma_wdata_ready_o,
  output dma_data_s       dma_rdata_o [2],
  input  wire logic [1:0] dma_rdata_ready_i
);

  wh_link_s   req_link [2];
  logic [1:0] req_ready;
  wh_link_s   mem_link;
  logic       mem_ready;
  wh_link_s   ret_link [2];
  logic [1:0] ret_ready;

  for (genvar c = 0; c < 2; c++) begin : g_cache
    dma_to_wormhole #(
      .src_cid_p(CID_WIDTH'(c))
    ) u_adapter (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .dma_pkt_i        (dma_pkt_i[c]),
      .dma_pkt_v_i      (dma_pkt_v_i[c]),
      .dma_pkt_ready_o  (dma_pkt_ready_o[c]),
      .dma_wdata_i      (dma_wdata_i[c]),
      .dma_wdata_ready_o(dma_wdata_ready_o[c]),
      .dma_rdata_o      (dma_rdata_o[c]),
      .dma_rdata_ready_i(dma_rdata_ready_i[c]),
      .req_link_o       (req_link[c]),
      .req_ready_i      (req_ready[c]),
      .ret_link_i       (ret_link[c]),
      .ret_ready_o      (ret_ready[c])
    );
  end

  wh_packet_arbiter u_arbiter (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_link_i (req_link),
    .req_ready_o(req_ready),
    .mem_link_o (mem_link),
    .mem_ready_i(mem_ready)
  );

  wh_memory_endpoint u_endpoint (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .mem_link_i (mem_link),
    .mem_ready_o(mem_ready),
    .ret_link_o (ret_link),
    .ret_ready_i(ret_ready)
  );

endmodule

`default_nettype wire

//--- dv/cache_dma_tb.sv
// self-checking testbench that runs as the simulation top for the two-cache DMA subsystem
`default_nettype none

module cache_dma_tb
  import cache_dma_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF = 20;
  localparam int RESET_CYCLES = 3;
  localparam int BLOCK_BYTES = BURST_LEN * DMA_DATA_WIDTH / 8;
  localparam int NUM_BLOCKS = MEM_WORDS / BURST_LEN;
  // request plus response flits per packet with a fourfold margin for stalls and queueing
  localparam int NUM_PKTS = 11;
  localparam int PKT_CYCLES = 4 * (3 + 2 * BURST_LEN);
  localparam int CYCLE_LIMIT = RESET_CYCLES + 8 + NUM_PKTS * PKT_CYCLES;

  logic       clk;
  logic       reset;
  dma_pkt_s   dma_pkt [2];
  logic [1:0] dma_pkt_v;
  logic [1:0] dma_pkt_ready;
  dma_data_s  dma_wdata [2];
  logic [1:0] dma_wdata_ready;
  dma_data_s  dma_rdata [2];
  logic [1:0] dma_rdata_ready;

  logic [31:0]               lfsr = 32'h1aec_9b87;
  logic [DMA_DATA_WIDTH-1:0] shadow [MEM_WORDS];
  logic [DMA_DATA_WIDTH-1:0] wr_words [2][BURST_LEN];
  logic [DMA_DATA_WIDTH-1:0] exp_q [2][$];
  logic [DMA_DATA_WIDTH-1:0] got_word [2];
  logic [DMA_DATA_WIDTH-1:0] exp_word [2];
  logic [1:0]                chk_v = '0;
  int                        words_left [2] = '{0, 0};
  int                        errors = 0;
  int                        tests_run = 0;
  int                        cycle_cnt = 0;
  logic                      stalling = 1'b0;

  cache_dma_top DUT (
    .clk_i            (clk),
    .reset_i          (reset),
    .dma_pkt_i        (dma_pkt),
    .dma_pkt_v_i      (dma_pkt_v),
    .dma_pkt_ready_o  (dma_pkt_ready),
    .dma_wdata_i      (dma_wdata),
    .dma_wdata_ready_o(dma_wdata_ready),
    .dma_rdata_o      (dma_rdata),
    .dma_rdata_ready_i(dma_rdata_ready)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [DMA_ADDR_WIDTH-1:0] blk_addr(input int blk);
    return DMA_ADDR_WIDTH'(blk * BLOCK_BYTES);
  endfunction

  function automatic int block_base(input logic [DMA_ADDR_WIDTH-1:0] byte_addr);
    return (int'(byte_addr) / BLOCK_BYTES) % NUM_BLOCKS * BURST_LEN;
  endfunction

  // picks data and mask and applies the write to the shadow memory up front
  function automatic logic [BURST_LEN-1:0] prepare_write(input int c, input int blk,
                                                         input logic masked);
    logic [BURST_LEN-1:0] mask;
    mask = '1;
    if (masked) begin
      mask = BURST_LEN'(take_bits(BURST_LEN));
      // at least one word is written and at least one is kept
      if (&mask) mask[0] = 1'b0;
      if (mask == '0) mask[0] = 1'b1;
    end
    for (int i = 0; i < BURST_LEN; i++) begin
      wr_words[c][i] = take_bits(DMA_DATA_WIDTH);
      if (mask[i]) shadow[blk * BURST_LEN + i] = wr_words[c][i];
    end
    return mask;
  endfunction

  // starts at a rising edge and returns at the edge where the packet was taken
  task automatic send_pkt(input int c, input logic wr, input logic [DMA_ADDR_WIDTH-1:0] byte_addr,
                          input logic [BURST_LEN-1:0] wmask);
    dma_pkt[c] <= '{write_not_read: wr, addr: byte_addr, mask: wmask};
    dma_pkt_v[c] <= 1'b1;
    @(negedge clk);
    while (!dma_pkt_ready[c]) @(negedge clk);
    @(posedge clk);
    dma_pkt_v[c] <= 1'b0;
  endtask

  task automatic send_wdata(input int c);
    for (int i = 0; i < BURST_LEN; i++) begin
      dma_wdata[c] <= '{v: 1'b1, data: wr_words[c][i]};
      @(negedge clk);
      while (!dma_wdata_ready[c]) @(negedge clk);
      @(posedge clk);
    end
    dma_wdata[c].v <= 1'b0;
  endtask

  task automatic write_block(input int c, input int blk, input logic masked);
    logic [BURST_LEN-1:0] mask;
    mask = prepare_write(c, blk, masked);
    fork
      send_pkt(c, 1'b1, blk_addr(blk), mask);
      send_wdata(c);
    join
  endtask

  task automatic read_block(input int c, input int blk);
    send_pkt(c, 1'b0, blk_addr(blk), '1);
  endtask

  task automatic wait_fills();
    wait (words_left[0] == 0 && words_left[1] == 0);
    @(posedge clk);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    $display("test %0d %s: %s", tests_run, name, (errors == errs_before) ? "ok" : "failed");
  endtask

  // handshakes are looked at mid-cycle once DUT outputs have settled
  always @(negedge clk) begin
    int base;
    for (int c = 0; c < 2; c++) begin
      chk_v[c] <= 1'b0;
      if (!reset && dma_pkt_v[c] && dma_pkt_ready[c] && !dma_pkt[c].write_not_read) begin
        base = block_base(dma_pkt[c].addr);
        for (int i = 0; i < BURST_LEN; i++) exp_q[c].push_back(shadow[base + i]);
        words_left[c] += BURST_LEN;
      end
      if (!reset && dma_rdata[c].v && dma_rdata_ready[c]) begin
        got_word[c] <= dma_rdata[c].data;
        exp_word[c] <= (exp_q[c].size() > 0) ? exp_q[c].pop_front() : '0;
        chk_v[c] <= 1'b1;
        words_left[c] -= 1;
      end
    end
  end

  for (genvar c = 0; c < 2; c++) begin : g_check
    assert property (@(posedge clk) disable iff (reset) chk_v[c] |-> got_word[c] == exp_word[c])
      else begin
        $display("FAILED t=%0t dma_rdata_o[%0d].data expected %h got %h",
                 $time, c, exp_word[c], got_word[c]);
        errors++;
      end

    // words_left already has this cycle's transfer taken off so chk_v adds it back
    assert property (@(posedge clk) disable iff (reset)
                     dma_rdata[c].v |-> (words_left[c] + int'(chk_v[c])) > 0)
      else begin
        $display("cache %0d got fill data with no read outstanding at %0t", c, $time);
        errors++;
      end

    assert property (@(posedge clk) disable iff (reset)
                     dma_rdata[c].v && !dma_rdata_ready[c]
                     |=> dma_rdata[c].v && $stable(dma_rdata[c].data))
      else begin
        $display("cache %0d fill data changed while stalled at %0t", c, $time);
        errors++;
      end
  end

  initial begin : watchdog
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles without finishing the tests", cycle_cnt);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int errs;
    logic [BURST_LEN-1:0] mask;
    reset = 1'b1;
    dma_pkt_v = '0;
    dma_rdata_ready = 2'b11;
    for (int c = 0; c < 2; c++) begin
      dma_pkt[c] = '0;
      dma_wdata[c] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    errs = errors;
    repeat (4) @(posedge clk);
    finish_test("reset", errs);

    errs = errors;
    write_block(0, 2, 1'b0);
    read_block(0, 2);
    wait_fills();
    finish_test("full write then read", errs);

    // cache 1 partly overwrites the block cache 0 just wrote
    errs = errors;
    write_block(1, 2, 1'b1);
    read_block(1, 2);
    wait_fills();
    finish_test("masked write", errs);

    errs = errors;
    fork
      begin
        write_block(0, 3, 1'b0);
        read_block(0, 3);
      end
      begin
        write_block(1, 7, 1'b0);
        read_block(1, 7);
      end
    join
    wait_fills();
    finish_test("two caches at once", errs);

    errs = errors;
    stalling = 1'b1;
    fork
      begin
        read_block(1, 7);
        wait_fills();
        stalling = 1'b0;
      end
      begin
        while (stalling) begin
          dma_rdata_ready[1] <= (take_bits(1) != 0);
          @(posedge clk);
        end
        dma_rdata_ready[1] <= 1'b1;
      end
    join
    finish_test("back-pressure", errs);

    // write and read packets offered in consecutive cycles
    errs = errors;
    mask = prepare_write(0, 12, 1'b0);
    fork
      begin
        send_pkt(0, 1'b1, blk_addr(12), mask);
        send_pkt(0, 1'b0, blk_addr(12), '1);
      end
      send_wdata(0);
    join
    wait_fills();
    finish_test("writeback then fill", errs);

    for (int c = 0; c < 2; c++) begin
      if (exp_q[c].size() != 0 || words_left[c] != 0) begin
        $display("cache %0d still expects %0d fill words at the end", c, words_left[c]);
        errors++;
      end
    end
    $display("tests run %0d, failing checks %0d", tests_run, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
design/cache_dma_pkg.sv
design/wh_flit_pkg.sv
design/dma_to_wormhole.sv
design/wh_packet_arbiter.sv
design/wh_memory_endpoint.sv
design/cache_dma_top.sv
dv/cache_dma_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and pass only if the run reports success
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module cache_dma_tb -Mdir obj_dir -f sources.f

out="$(./obj_dir/Vcache_dma_tb)"
echo "$out"

if grep -qx "All tests passed" <<< "$out"; then
  exit 0
fi
exit 1
